//--- mem_pkg.sv
// Shared memory subsystem definitions
package mem_pkg;

    // Bus widths
    localparam int unsigned ADDR_WIDTH = 64;
    localparam int unsigned DATA_WIDTH = 64;
    localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;

    // Debug region in the shared map
    localparam addr_t DEBUG_BASE   = 64'h0000_0000_1200_0000;
    localparam addr_t DEBUG_LENGTH = 64'h0000_0000_0000_1000;
    localparam int unsigned DEBUG_WORDS = 32'(DEBUG_LENGTH / 8);

    // Core port is 0, debug port is 1
    localparam int unsigned NUM_PORTS = 2;

    typedef logic port_id_t;

    // Single word request from a port
    typedef struct packed {
        addr_t addr;
        logic  we;
        strb_t be;
        data_t wdata;
    } mem_req_t;

    // Response returned with ack
    typedef struct packed {
        data_t rdata;
        logic  err;
    } mem_rsp_t;

endpackage

//--- sram_bank.sv
// Byte-enable word memory
`timescale 1ns/1ps

module sram_bank #(
    parameter int unsigned NUM_WORDS = 1024
) (
    input  logic                         clk_i,
    input  logic                         en_i,
    input  logic                         we_i,
    input  logic [$clog2(NUM_WORDS)-1:0] addr_i,
    input  mem_pkg::data_t               wdata_i,
    input  mem_pkg::strb_t               be_i,
    output mem_pkg::data_t               rdata_o
);
    import mem_pkg::*;

    localparam int unsigned AW = $clog2(NUM_WORDS);

    data_t         ram [NUM_WORDS];
    logic [AW-1:0] raddr_q;

    // Banks start out empty
    initial begin
        for (int i = 0; i < NUM_WORDS; i++) begin
            ram[i] = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                for (int b = 0; b < STRB_WIDTH; b++) begin
                    if (be_i[b]) begin
                        ram[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end else begin
                raddr_q <= addr_i;
            end
        end
    end

    assign rdata_o = ram[raddr_q];

endmodule

//--- req_arbiter.sv
// Round-robin request arbiter
`timescale 1ns/1ps

module req_arbiter (
    input  logic                                       clk_i,
    input  logic                                       reset_i,
    input  logic [mem_pkg::NUM_PORTS-1:0]              port_req_i,
    input  mem_pkg::mem_req_t [mem_pkg::NUM_PORTS-1:0] port_data_i,
    input  logic                                       done_i,
    output logic                                       valid_o,
    output mem_pkg::mem_req_t                          req_o,
    output mem_pkg::port_id_t                          src_o
);
    import mem_pkg::*;

    logic     busy_q;
    port_id_t rr_q;
    logic     valid_q;
    mem_req_t req_q;
    port_id_t src_q;

    logic     free;
    logic     grant_vld;
    port_id_t grant_id;
    port_id_t other_id;

    // Done frees the arbiter in the same cycle
    assign free = !busy_q || done_i;

    assign other_id = rr_q + 1'b1;

    always_comb begin
        grant_vld = |port_req_i;
        if (port_req_i[rr_q]) begin
            grant_id = rr_q;
        end else begin
            grant_id = other_id;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q  <= 1'b0;
            rr_q    <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (free && grant_vld) begin
                busy_q  <= 1'b1;
                valid_q <= 1'b1;
                // Favour the port that lost this round
                rr_q    <= grant_id + 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Payload captured at grant
    always_ff @(posedge clk_i) begin
        if (free && grant_vld) begin
            req_q <= port_data_i[grant_id];
            src_q <= grant_id;
        end
    end

    assign valid_o = valid_q;
    assign req_o   = req_q;
    assign src_o   = src_q;

endmodule

//--- mem_router.sv
// Address decode and bank access
`timescale 1ns/1ps

module mem_router #(
    parameter int unsigned MEM_WORDS = 4096
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              valid_i,
    input  mem_pkg::mem_req_t req_i,
    input  mem_pkg::port_id_t src_i,
    output logic              valid_o,
    output mem_pkg::mem_rsp_t rsp_o,
    output mem_pkg::port_id_t src_o
);
    import mem_pkg::*;

    localparam int unsigned MAIN_AW    = $clog2(MEM_WORDS);
    localparam int unsigned DBG_AW     = $clog2(DEBUG_WORDS);
    localparam addr_t       MAIN_LIMIT = addr_t'(MEM_WORDS) << 3;

    logic               main_hit;
    logic               debug_hit;
    addr_t              debug_offset;
    logic [MAIN_AW-1:0] main_index;
    logic [DBG_AW-1:0]  debug_index;
    data_t              main_rdata;
    data_t              debug_rdata;

    logic     valid_q;
    logic     sel_debug_q;
    logic     err_q;
    logic     we_q;
    port_id_t src_q;
    mem_rsp_t rsp_d;
    logic     valid_out_q;
    mem_rsp_t rsp_q;
    port_id_t src_out_q;

    // Main bank wins if the two ranges ever overlap
    assign main_hit     = req_i.addr < MAIN_LIMIT;
    assign debug_hit    = !main_hit && (req_i.addr >= DEBUG_BASE)
                          && (req_i.addr < DEBUG_BASE + DEBUG_LENGTH);
    assign debug_offset = req_i.addr - DEBUG_BASE;
    assign main_index   = req_i.addr[MAIN_AW+2:3];
    assign debug_index  = debug_offset[DBG_AW+2:3];

    sram_bank #(
        .NUM_WORDS ( MEM_WORDS )
    ) i_main_bank (
        .clk_i   ( clk_i               ),
        .en_i    ( valid_i && main_hit ),
        .we_i    ( req_i.we            ),
        .addr_i  ( main_index          ),
        .wdata_i ( req_i.wdata         ),
        .be_i    ( req_i.be            ),
        .rdata_o ( main_rdata          )
    );

    sram_bank #(
        .NUM_WORDS ( DEBUG_WORDS )
    ) i_debug_bank (
        .clk_i   ( clk_i                ),
        .en_i    ( valid_i && debug_hit ),
        .we_i    ( req_i.we             ),
        .addr_i  ( debug_index          ),
        .wdata_i ( req_i.wdata          ),
        .be_i    ( req_i.be             ),
        .rdata_o ( debug_rdata          )
    );

    // Access stage
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            sel_debug_q <= debug_hit;
            err_q       <= !main_hit && !debug_hit;
            we_q        <= req_i.we;
            src_q       <= src_i;
        end
    end

    always_comb begin
        rsp_d.err = err_q;
        if (err_q || we_q) begin
            rsp_d.rdata = '0;
        end else if (sel_debug_q) begin
            rsp_d.rdata = debug_rdata;
        end else begin
            rsp_d.rdata = main_rdata;
        end
    end

    // Response stage
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q     <= 1'b0;
            valid_out_q <= 1'b0;
        end else begin
            valid_q     <= valid_i;
            valid_out_q <= valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_q) begin
            rsp_q     <= rsp_d;
            src_out_q <= src_q;
        end
    end

    assign valid_o = valid_out_q;
    assign rsp_o   = rsp_q;
    assign src_o   = src_out_q;

endmodule

//--- rsp_return.sv
// Response return and ack handshake
`timescale 1ns/1ps

module rsp_return (
    input  logic                                       clk_i,
    input  logic                                       reset_i,
    input  logic                                       valid_i,
    input  mem_pkg::mem_rsp_t                          rsp_i,
    input  mem_pkg::port_id_t                          src_i,
    input  logic [mem_pkg::NUM_PORTS-1:0]              port_req_i,
    output logic [mem_pkg::NUM_PORTS-1:0]              port_ack_o,
    output mem_pkg::mem_rsp_t [mem_pkg::NUM_PORTS-1:0] port_rsp_o,
    output logic                                       done_o
);
    import mem_pkg::*;

    logic [NUM_PORTS-1:0]     ack_q;
    port_id_t                 src_q;
    mem_rsp_t [NUM_PORTS-1:0] rsp_q;
    logic                     done_q;
    logic                     release_w;

    // Owning port has dropped req
    assign release_w = ack_q[src_q] && !port_req_i[src_q];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_q  <= '0;
            src_q  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= release_w;
            if (valid_i) begin
                ack_q[src_i] <= 1'b1;
                src_q        <= src_i;
            end else if (release_w) begin
                ack_q[src_q] <= 1'b0;
            end
        end
    end

    // Response held until the port releases
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            rsp_q[src_i] <= rsp_i;
        end
    end

    assign port_ack_o = ack_q;
    assign port_rsp_o = rsp_q;
    assign done_o     = done_q;

endmodule

//--- mem_top.sv
// Shared memory subsystem top
`timescale 1ns/1ps

module mem_top #(
    parameter int unsigned MEM_WORDS = 4096
) (
    input  logic                                       clk_i,
    input  logic                                       reset_i,
    input  logic [mem_pkg::NUM_PORTS-1:0]              port_req_i,
    input  mem_pkg::mem_req_t [mem_pkg::NUM_PORTS-1:0] port_data_i,
    output logic [mem_pkg::NUM_PORTS-1:0]              port_ack_o,
    output mem_pkg::mem_rsp_t [mem_pkg::NUM_PORTS-1:0] port_rsp_o
);
    import mem_pkg::*;

    logic     arb_valid;
    mem_req_t arb_req;
    port_id_t arb_src;
    logic     rtr_valid;
    mem_rsp_t rtr_rsp;
    port_id_t rtr_src;
    logic     done;

    req_arbiter i_req_arbiter (
        .clk_i       ( clk_i       ),
        .reset_i     ( reset_i     ),
        .port_req_i  ( port_req_i  ),
        .port_data_i ( port_data_i ),
        .done_i      ( done        ),
        .valid_o     ( arb_valid   ),
        .req_o       ( arb_req     ),
        .src_o       ( arb_src     )
    );

    mem_router #(
        .MEM_WORDS ( MEM_WORDS )
    ) i_mem_router (
        .clk_i   ( clk_i     ),
        .reset_i ( reset_i   ),
        .valid_i ( arb_valid ),
        .req_i   ( arb_req   ),
        .src_i   ( arb_src   ),
        .valid_o ( rtr_valid ),
        .rsp_o   ( rtr_rsp   ),
        .src_o   ( rtr_src   )
    );

    rsp_return i_rsp_return (
        .clk_i      ( clk_i      ),
        .reset_i    ( reset_i    ),
        .valid_i    ( rtr_valid  ),
        .rsp_i      ( rtr_rsp    ),
        .src_i      ( rtr_src    ),
        .port_req_i ( port_req_i ),
        .port_ack_o ( port_ack_o ),
        .port_rsp_o ( port_rsp_o ),
        .done_o     ( done       )
    );

endmodule

//--- tb_clock.sv
// Testbench clock source
`timescale 1ns/1ps

module tb_clock #(
    parameter int unsigned PERIOD_NS = 4
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

//--- mem_assertions.sv
// Port handshake assertions
`timescale 1ns/1ps

module mem_assertions (
    input logic                          clk_i,
    input logic                          reset_i,
    input logic [mem_pkg::NUM_PORTS-1:0] port_req_i,
    input logic [mem_pkg::NUM_PORTS-1:0] port_ack_i
);
    import mem_pkg::*;

    // Single transaction in flight
    a_one_ack: assert property (@(posedge clk_i) disable iff (reset_i)
        !(&port_ack_i))
        else $error("both port acks high together");

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        // Ack rose on an edge that saw req high
        a_ack_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
            $rose(port_ack_i[p]) |-> $past(port_req_i[p]))
            else $error("ack of port %0d rose without req", p);

        a_ack_holds: assert property (@(posedge clk_i) disable iff (reset_i)
            (port_ack_i[p] && port_req_i[p]) |=> port_ack_i[p])
            else $error("ack of port %0d dropped while req high", p);
    end

endmodule

//--- tb_mem_top.sv
// Shared memory testbench
`timescale 1ns/1ps

module tb_mem_top;
    import mem_pkg::*;

    localparam int unsigned MEM_WORDS    = 4096;
    localparam int unsigned MAIN_AW      = $clog2(MEM_WORDS);
    localparam int unsigned DBG_AW       = $clog2(DEBUG_WORDS);
    localparam addr_t       MAIN_BYTES   = addr_t'(MEM_WORDS) * 8;
    localparam int unsigned CLK_PERIOD   = 4;
    localparam int unsigned RESET_CYCLES = 5;
    localparam logic [31:0] LFSR_SEED    = 32'h2cc3319b;

    localparam int N_ZERO  = 16;
    localparam int N_MAIN  = 300;
    localparam int N_DEBUG = 300;
    localparam int N_PAIR  = 16;
    localparam int N_ERR   = 64;
    localparam int N_BOTH  = 150;
    localparam int TOTAL_TXNS = N_ZERO + N_MAIN + N_DEBUG + 2 * N_PAIR + N_ERR
                                + 2 * N_BOTH + MEM_WORDS + DEBUG_WORDS;
    localparam int WATCHDOG_NS = (TOTAL_TXNS * 20 + RESET_CYCLES) * CLK_PERIOD;

    logic                      clk;
    logic                      reset;
    logic [NUM_PORTS-1:0]      port_req;
    mem_req_t [NUM_PORTS-1:0]  port_data;
    logic [NUM_PORTS-1:0]      port_ack;
    mem_rsp_t [NUM_PORTS-1:0]  port_rsp;

    logic [31:0]          lfsr_state;
    logic [7:0]           main_model [MEM_WORDS * 8];
    logic [7:0]           debug_model [DEBUG_WORDS * 8];
    logic [NUM_PORTS-1:0] ack_prev;
    logic                 alternate_check;
    logic                 have_last;
    port_id_t             last_port;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) i_clock (.clk_o(clk));

    mem_top #(
        .MEM_WORDS ( MEM_WORDS )
    ) i_dut (
        .clk_i       ( clk       ),
        .reset_i     ( reset     ),
        .port_req_i  ( port_req  ),
        .port_data_i ( port_data ),
        .port_ack_o  ( port_ack  ),
        .port_rsp_o  ( port_rsp  )
    );

    bind mem_top mem_assertions i_mem_assertions (
        .clk_i      ( clk_i      ),
        .reset_i    ( reset_i    ),
        .port_req_i ( port_req_i ),
        .port_ack_i ( port_ack_o )
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_rsp(input mem_rsp_t got, input mem_rsp_t exp, input port_id_t p,
                             input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: %s port %0d rdata %h err %b, expected rdata %h err %b",
                                $time, what, p, got.rdata, got.err, exp.rdata, exp.err));
        end
    endtask

    task automatic check_ack(input logic [NUM_PORTS-1:0] got, input logic [NUM_PORTS-1:0] exp,
                             input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: %s ack %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_port(input port_id_t got, input port_id_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: port %0d completed, expected port %0d",
                                $time, got, exp));
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("ERR %0t: ack after %0d cycles, expected %0d", $time, got, exp));
        end
    endtask

    // Galois LFSR with taps for x^32 + x^30 + x^26 + x^25 + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'hA300_0000;
        end
        return n;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Mostly a small window so reads hit earlier writes
    function automatic addr_t main_addr();
        addr_t idx;
        if (rand_bits(1) != 0) begin
            idx = rand_bits(6);
        end else begin
            idx = rand_bits(MAIN_AW);
        end
        return (idx << 3) | rand_bits(3);
    endfunction

    function automatic addr_t debug_addr();
        addr_t      off;
        logic [1:0] sel;
        sel = 2'(rand_bits(2));
        case (sel)
            2'd0:    off = '0;
            2'd1:    off = DEBUG_LENGTH - 8;
            default: off = rand_bits(DBG_AW) << 3;
        endcase
        return DEBUG_BASE + off + rand_bits(3);
    endfunction

    function automatic addr_t err_addr();
        logic [1:0] sel;
        sel = 2'(rand_bits(2));
        case (sel)
            2'd0:    return MAIN_BYTES + rand_bits(12);
            2'd1:    return DEBUG_BASE - 64'd1 - rand_bits(12);
            2'd2:    return DEBUG_BASE + DEBUG_LENGTH + rand_bits(12);
            default: return {1'b1, 63'(rand_bits(63))};
        endcase
    endfunction

    function automatic addr_t any_addr();
        logic [1:0] sel;
        sel = 2'(rand_bits(2));
        case (sel)
            2'd1:    return debug_addr();
            2'd2:    return err_addr();
            default: return main_addr();
        endcase
    endfunction

    function automatic mem_req_t rand_req(input addr_t addr, input logic allow_write);
        mem_req_t req;
        req.addr  = addr;
        req.we    = allow_write && (rand_bits(1) != 0);
        req.be    = strb_t'(rand_bits(STRB_WIDTH));
        req.wdata = data_t'(rand_bits(DATA_WIDTH));
        return req;
    endfunction

    // Byte-level reference of the memory map
    function automatic mem_rsp_t model_access(input mem_req_t req);
        mem_rsp_t rsp;
        addr_t    word;
        logic     in_main;
        logic     in_debug;
        rsp      = '0;
        word     = {req.addr[ADDR_WIDTH-1:3], 3'b000};
        in_main  = req.addr < MAIN_BYTES;
        in_debug = (req.addr >= DEBUG_BASE) && (req.addr < DEBUG_BASE + DEBUG_LENGTH);
        if (!in_main && !in_debug) begin
            rsp.err = 1'b1;
            return rsp;
        end
        if (in_debug) begin
            word = word - DEBUG_BASE;
        end
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (req.we && req.be[b] && in_main) begin
                main_model[word + b] = req.wdata[b*8 +: 8];
            end else if (req.we && req.be[b]) begin
                debug_model[word + b] = req.wdata[b*8 +: 8];
            end else if (!req.we && in_main) begin
                rsp.rdata[b*8 +: 8] = main_model[word + b];
            end else if (!req.we) begin
                rsp.rdata[b*8 +: 8] = debug_model[word + b];
            end
        end
        return rsp;
    endfunction

    // Full four-phase handshake on one port
    task automatic run_txn(input port_id_t p, input mem_req_t req, input int hold,
                           input logic timed);
        mem_rsp_t             exp;
        logic [NUM_PORTS-1:0] one_hot;
        int                   waited;
        one_hot    = '0;
        one_hot[p] = 1'b1;
        waited     = 0;
        @(negedge clk);
        port_data[p] = req;
        port_req[p]  = 1'b1;
        do begin
            @(negedge clk);
            waited++;
        end while (!port_ack[p]);
        exp = model_access(req);
        if (timed) begin
            check_latency(waited, 4);
        end
        check_ack(port_ack, one_hot, "completion");
        check_rsp(port_rsp[p], exp, p, "response");
        repeat (hold) begin
            @(negedge clk);
            check_ack(port_ack, one_hot, "held req");
            check_rsp(port_rsp[p], exp, p, "held response");
        end
        port_req[p]  = 1'b0;
        port_data[p] = '0;
        do begin
            @(negedge clk);
        end while (port_ack[p]);
    endtask

    task automatic seq_txn(input mem_req_t req);
        run_txn(port_id_t'(rand_bits(1)), req, 0, 1'b1);
    endtask

    task automatic port_stream(input port_id_t p, input int count);
        mem_req_t req;
        int       hold;
        for (int i = 0; i < count; i++) begin
            req  = rand_req(any_addr(), 1'b1);
            hold = int'(rand_bits(3));
            run_txn(p, req, hold, 1'b0);
        end
    endtask

    // Completion order
    always @(negedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (port_ack[p] && !ack_prev[p]) begin
                if (alternate_check && have_last) begin
                    check_port(port_id_t'(p), ~last_port);
                end
                last_port = port_id_t'(p);
                have_last = 1'b1;
            end
        end
        ack_prev = port_ack;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("Timeout: transactions did not complete");
    end

    initial begin
        addr_t k;
        mem_req_t req;
        lfsr_state      = LFSR_SEED;
        reset           = 1'b1;
        port_req        = '0;
        port_data       = '0;
        ack_prev        = '0;
        alternate_check = 1'b0;
        have_last       = 1'b0;
        last_port       = '0;
        for (int i = 0; i < MEM_WORDS * 8; i++) begin
            main_model[i] = '0;
        end
        for (int i = 0; i < DEBUG_WORDS * 8; i++) begin
            debug_model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_ack(port_ack, '0, "after reset");

        // Unwritten words read as zero
        for (int i = 0; i < N_ZERO; i++) begin
            if (rand_bits(1) != 0) begin
                seq_txn(rand_req(debug_addr(), 1'b0));
            end else begin
                seq_txn(rand_req(main_addr(), 1'b0));
            end
        end
        for (int i = 0; i < N_MAIN; i++) begin
            seq_txn(rand_req(main_addr(), 1'b1));
        end
        for (int i = 0; i < N_DEBUG; i++) begin
            seq_txn(rand_req(debug_addr(), 1'b1));
        end

        // Debug word k against main word k
        for (int i = 0; i < N_PAIR; i++) begin
            k = rand_bits(6);
            req = rand_req(DEBUG_BASE + (k << 3), 1'b0);
            req.we = 1'b1;
            seq_txn(req);
            seq_txn(rand_req(k << 3, 1'b0));
        end
        for (int i = 0; i < N_ERR; i++) begin
            seq_txn(rand_req(err_addr(), 1'b1));
        end

        // Both ports competing with random holds
        have_last       = 1'b0;
        alternate_check = 1'b1;
        fork
            port_stream(1'b0, N_BOTH);
            port_stream(1'b1, N_BOTH);
        join
        alternate_check = 1'b0;

        for (int i = 0; i < MEM_WORDS; i++) begin
            seq_txn(rand_req(addr_t'(i) << 3, 1'b0));
        end
        for (int i = 0; i < DEBUG_WORDS; i++) begin
            seq_txn(rand_req(DEBUG_BASE + (addr_t'(i) << 3), 1'b0));
        end

        $display("No errors");
        $finish;
    end

endmodule

//--- vlog.f
mem_pkg.sv
sram_bank.sv
req_arbiter.sv
mem_router.sv
rsp_return.sv
mem_top.sv
tb_clock.sv
mem_assertions.sv
tb_mem_top.sv
